//--- sources.f
design/rv_pkg.sv
design/rv_ifu.sv
design/rv_idu.sv
design/rv_gpr.sv
design/rv_exu.sv
design/rv_lsu.sv
design/rv_npc.sv
verification/tb_npc.sv

//--- Bender.yml
package:
  name: rv_npc

sources:
  - design/rv_pkg.sv
  - design/rv_ifu.sv
  - design/rv_idu.sv
  - design/rv_gpr.sv
  - design/rv_exu.sv
  - design/rv_lsu.sv
  - design/rv_npc.sv
  - target: test
    files:
      - verification/tb_npc.sv

//--- verification/tb_npc.sv
// testbench for the RV64I core that loads a short program, runs it and checks pc and write-back per step
module tb_npc;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_pkg::*;

  localparam int          IMEM_DEPTH  = 64;
  localparam int          DMEM_DEPTH  = 64;
  localparam int          AW          = $clog2(IMEM_DEPTH);
  localparam xlen_t       END_PC      = 64'd144;
  localparam xlen_t       PAUSE_PC    = 64'd136;
  localparam int          END_TIMEOUT = 20;            // cycles
  localparam logic [31:0] halt_word   = 32'h0000_006f; // jal x0, 0

  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jalr  = 7'b1100111;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_imm   = 7'b0010011;

  typedef struct packed {
    logic [31:0] inst;
    xlen_t       pc;
    logic        en;
    logic [4:0]  rd;
    xlen_t       data;
  } step_t;

  logic          clk = 1'b0;
  logic          reset;
  logic          run;
  logic          imem_we;
  logic [AW-1:0] imem_addr;
  logic [31:0]   imem_data;
  xlen_t         pc;
  wb_t           wb;
  step_t         tbl[$];
  logic          reached;

  rv_npc #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_rv_npc (
    .i_clk(clk), .i_reset(reset), .i_run(run),
    .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_pc(pc), .o_wb(wb)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_word(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_step(input logic [31:0] inst, input xlen_t step_pc, input logic en,
                          input logic [4:0] rd, input xlen_t data);
    tbl.push_back('{inst: inst, pc: step_pc, en: en, rd: rd, data: data});
  endtask

  // execution order; words that a jump or branch skips are never loaded
  task automatic build_table();
    add_step(i_word(op_imm, 3'b000, 5'd1, 5'd0, 12'd5), 0, 1'b1, 5'd1, 64'd5);
    add_step(i_word(op_imm, 3'b000, 5'd2, 5'd0, 12'hffd), 4, 1'b1, 5'd2, -64'd3);
    add_step(r_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 8, 1'b1, 5'd3, 64'd2);
    add_step(r_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), 12, 1'b1, 5'd4, 64'd8);
    add_step(u_word(op_lui, 5'd5, 20'h12345), 16, 1'b1, 5'd5, 64'h1234_5000);
    add_step(r_word(7'h00, 3'b100, 5'd6, 5'd1, 5'd2), 20, 1'b1, 5'd6, -64'd8);
    add_step(r_word(7'h00, 3'b110, 5'd7, 5'd1, 5'd2), 24, 1'b1, 5'd7, -64'd3);
    add_step(r_word(7'h00, 3'b111, 5'd8, 5'd1, 5'd2), 28, 1'b1, 5'd8, 64'd5);
    add_step(r_word(7'h00, 3'b001, 5'd9, 5'd1, 5'd3), 32, 1'b1, 5'd9, 64'd20);
    add_step(r_word(7'h20, 3'b101, 5'd10, 5'd2, 5'd3), 36, 1'b1, 5'd10, -64'd1);
    add_step(r_word(7'h00, 3'b010, 5'd11, 5'd2, 5'd1), 40, 1'b1, 5'd11, 64'd1);
    add_step(r_word(7'h00, 3'b011, 5'd12, 5'd2, 5'd1), 44, 1'b1, 5'd12, 64'd0);
    add_step(i_word(op_imm, 3'b000, 5'd0, 5'd1, 12'd7), 48, 1'b1, 5'd0, 64'd12); // to x0
    add_step(r_word(7'h00, 3'b000, 5'd13, 5'd0, 5'd1), 52, 1'b1, 5'd13, 64'd5);
    // sd then byte and half stores merged into the same doubleword at 64
    add_step(i_word(op_imm, 3'b000, 5'd14, 5'd0, 12'd64), 56, 1'b1, 5'd14, 64'd64);
    add_step(s_word(3'b011, 5'd14, 5'd5, 12'd0), 60, 1'b0, 5'd0, 64'd0);
    add_step(i_word(op_load, 3'b011, 5'd15, 5'd14, 12'd0), 64, 1'b1, 5'd15, 64'h1234_5000);
    add_step(s_word(3'b000, 5'd14, 5'd2, 12'd1), 68, 1'b0, 5'd0, 64'd0);
    add_step(s_word(3'b001, 5'd14, 5'd2, 12'd2), 72, 1'b0, 5'd0, 64'd0);
    add_step(i_word(op_load, 3'b100, 5'd16, 5'd14, 12'd1), 76, 1'b1, 5'd16, 64'hfd);
    add_step(i_word(op_load, 3'b000, 5'd17, 5'd14, 12'd1), 80, 1'b1, 5'd17, -64'd3);
    add_step(i_word(op_load, 3'b101, 5'd18, 5'd14, 12'd2), 84, 1'b1, 5'd18, 64'hfffd);
    add_step(i_word(op_load, 3'b110, 5'd19, 5'd14, 12'd0), 88, 1'b1, 5'd19, 64'hfffd_fd00);
    // beq taken, bne not taken, blt taken, bgeu not taken
    add_step(b_word(3'b000, 5'd1, 5'd13, 13'd8), 92, 1'b0, 5'd0, 64'd0);
    add_step(b_word(3'b001, 5'd1, 5'd13, 13'd8), 100, 1'b0, 5'd0, 64'd0);
    add_step(b_word(3'b100, 5'd2, 5'd1, 13'd8), 104, 1'b0, 5'd0, 64'd0);
    add_step(b_word(3'b111, 5'd1, 5'd2, 13'd8), 112, 1'b0, 5'd0, 64'd0);
    add_step(j_word(5'd20, 21'd12), 116, 1'b1, 5'd20, 64'd120);
    add_step(i_word(op_jalr, 3'b000, 5'd21, 5'd20, 12'd17), 128, 1'b1, 5'd21, 64'd132);
    add_step(i_word(op_imm, 3'b000, 5'd22, 5'd22, 12'd1), 136, 1'b1, 5'd22, 64'd1);
    add_step(u_word(op_auipc, 5'd23, 20'h00001), 140, 1'b1, 5'd23, 64'd4236);
  endtask

  task automatic check(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("FAILED at time %0d ns: %s got %h expected %h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic compare_step(input int k);
    check($sformatf("o_pc (step %0d)", k), pc, tbl[k].pc);
    check($sformatf("o_wb.en (step %0d)", k), wb.en, tbl[k].en);
    if (tbl[k].en) begin
      check($sformatf("o_wb.rd (step %0d)", k), wb.rd, tbl[k].rd);
      check($sformatf("o_wb.data (step %0d)", k), wb.data, tbl[k].data);
    end
  endtask

  // one word per cycle with the core halted and the halt loop written last
  task automatic load_program();
    for (int k = 0; k <= tbl.size(); k++) begin
      @(posedge clk);
      imem_we <= 1'b1;
      if (k < tbl.size()) begin
        imem_addr <= tbl[k].pc[AW+1:2];
        imem_data <= tbl[k].inst;
      end else begin
        imem_addr <= END_PC[AW+1:2];
        imem_data <= halt_word;
      end
      @(negedge clk);
      check("o_pc while loading", pc, '0);
      check("o_wb.en while loading", wb.en, '0);
    end
  endtask

  // entered right after the previous step retired
  task automatic hold_run(input xlen_t held_pc);
    run <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check("o_pc while halted", pc, held_pc);
      check("o_wb.en while halted", wb.en, '0);
      @(posedge clk);
    end
    run <= 1'b1;
  endtask

  task automatic wait_end(output logic hit);
    int cycles;
    hit    = 1'b0;
    cycles = 0;
    while (!hit && cycles < END_TIMEOUT) begin
      @(negedge clk);
      hit = (pc == END_PC);
      cycles++;
    end
  endtask

  initial begin
    reset     <= 1'b1;
    run       <= 1'b0;
    imem_we   <= 1'b0;
    imem_addr <= '0;
    imem_data <= '0;
    build_table();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    load_program();
    @(posedge clk);
    imem_we <= 1'b0;
    run     <= 1'b1;
    for (int k = 0; k < tbl.size(); k++) begin
      if (tbl[k].pc == PAUSE_PC) begin
        hold_run(tbl[k].pc); // the self-increment after resume shows no write while halted
      end
      @(negedge clk);
      compare_step(k);
      @(posedge clk);
    end
    wait_end(reached);
    if (reached) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("program did not reach its end PC within %0d cycles", END_TIMEOUT);
      $display("Result: FAILED");
      $fatal(1, "end of program not reached");
    end
  end
endmodule

//--- design/rv_npc.sv
// top of the single-cycle RV64I core; load the program with i_run low, then raise i_run
module rv_npc #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_run,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  output rv_pkg::xlen_t                 o_pc,
  output rv_pkg::wb_t                   o_wb
);

  import rv_pkg::*;

  xlen_t      pc;
  inst_u      inst;
  logic [4:0] ra;
  logic [4:0] rb;
  logic [4:0] rd;
  xlen_t      imm;
  ctrl_t      ctrl;
  xlen_t      rs1;
  xlen_t      rs2;
  xlen_t      alu_result;
  logic       less;
  logic       zero;
  xlen_t      wb_data;
  logic       reg_wen;
  logic       mem_wen;

  assign reg_wen = ctrl.reg_wr & i_run; // state only changes while running
  assign mem_wen = ctrl.mem_wr & i_run;

  rv_ifu #(.IMEM_DEPTH(IMEM_DEPTH)) u_ifu (
    .i_clk(i_clk), .i_reset(i_reset), .i_run(i_run),
    .i_branch(ctrl.branch), .i_less(less), .i_zero(zero),
    .i_imm(imm), .i_rs1(rs1),
    .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
    .o_pc(pc), .o_inst(inst)
  );

  rv_idu u_idu (
    .i_inst(inst),
    .o_ra(ra), .o_rb(rb), .o_rd(rd),
    .o_imm(imm), .o_ctrl(ctrl)
  );

  rv_gpr u_gpr (
    .i_clk(i_clk), .i_reset(i_reset), .i_wen(reg_wen),
    .i_ra(ra), .i_rb(rb), .i_waddr(rd), .i_wdata(wb_data),
    .o_bus_a(rs1), .o_bus_b(rs2)
  );

  rv_exu u_exu (
    .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm), .i_pc(pc), .i_ctrl(ctrl),
    .o_result(alu_result), .o_less(less), .o_zero(zero)
  );

  rv_lsu #(.DMEM_DEPTH(DMEM_DEPTH)) u_lsu (
    .i_clk(i_clk), .i_wen(mem_wen),
    .i_addr(alu_result), .i_wdata(rs2), .i_ctrl(ctrl), .i_alu(alu_result),
    .o_wb_data(wb_data)
  );

  assign o_pc = pc;
  assign o_wb = '{en: reg_wen, rd: rd, data: wb_data};
endmodule

//--- design/rv_lsu.sv
// load/store unit: doubleword data memory with byte lanes, load extension and write-back mux
module rv_lsu #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic          i_clk,
  input  logic          i_wen,
  input  rv_pkg::xlen_t i_addr,
  input  rv_pkg::xlen_t i_wdata,
  input  rv_pkg::ctrl_t i_ctrl,
  input  rv_pkg::xlen_t i_alu,
  output rv_pkg::xlen_t o_wb_data
);

  import rv_pkg::*;

  localparam int AW = $clog2(DMEM_DEPTH);

  xlen_t         dmem [DMEM_DEPTH];
  logic [AW-1:0] index;
  logic [2:0]    offs;       // byte within the doubleword
  logic [7:0]    size_mask;
  logic [7:0]    lanes;
  xlen_t         wdata_sh;
  xlen_t         rdata_sh;
  xlen_t         load_data;

  assign index    = i_addr[AW+2:3];
  assign offs     = i_addr[2:0];
  assign wdata_sh = i_wdata << {offs, 3'b000};
  assign rdata_sh = dmem[index] >> {offs, 3'b000};

  always_comb begin
    case (i_ctrl.mem_op[1:0])
      2'b00:   size_mask = 8'h01;
      2'b01:   size_mask = 8'h03;
      2'b10:   size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  assign lanes = size_mask << offs;

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int k = 0; k < 8; k++) begin
        if (lanes[k]) begin
          dmem[index][8*k +: 8] <= wdata_sh[8*k +: 8];
        end
      end
    end
  end

  always_comb begin
    case (i_ctrl.mem_op)
      mem_b:   load_data = {{56{rdata_sh[7]}}, rdata_sh[7:0]};
      mem_h:   load_data = {{48{rdata_sh[15]}}, rdata_sh[15:0]};
      mem_w:   load_data = {{32{rdata_sh[31]}}, rdata_sh[31:0]};
      mem_bu:  load_data = {56'd0, rdata_sh[7:0]};
      mem_hu:  load_data = {48'd0, rdata_sh[15:0]};
      mem_wu:  load_data = {32'd0, rdata_sh[31:0]};
      default: load_data = rdata_sh;  // ld
    endcase
  end

  assign o_wb_data = i_ctrl.mem_to_reg ? load_data : i_alu;
endmodule

//--- design/rv_exu.sv
// execute unit: operand muxes, 64-bit ALU and the compare flags used by branches
module rv_exu (
  input  rv_pkg::xlen_t i_rs1,
  input  rv_pkg::xlen_t i_rs2,
  input  rv_pkg::xlen_t i_imm,
  input  rv_pkg::xlen_t i_pc,
  input  rv_pkg::ctrl_t i_ctrl,
  output rv_pkg::xlen_t o_result,
  output logic          o_less,
  output logic          o_zero
);

  import rv_pkg::*;

  xlen_t      op_a;
  xlen_t      op_b;
  xlen_t      result;
  logic [5:0] shamt;
  logic       less_s;
  logic       less_u;

  assign op_a = (i_ctrl.a_src == a_src_pc) ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.b_src)
      b_src_rs2: op_b = i_rs2;
      b_src_imm: op_b = i_imm;
      default:   op_b = 64'd4;
    endcase
  end

  assign shamt  = op_b[5:0];
  assign less_s = $signed(op_a) < $signed(op_b);
  assign less_u = op_a < op_b;

  always_comb begin
    case (i_ctrl.alu_op)
      alu_add:   result = op_a + op_b;
      alu_sub:   result = op_a - op_b;
      alu_sll:   result = op_a << shamt;
      alu_slt:   result = {63'd0, less_s};
      alu_sltu:  result = {63'd0, less_u};
      alu_xor:   result = op_a ^ op_b;
      alu_srl:   result = op_a >> shamt;
      alu_sra:   result = $signed(op_a) >>> shamt;
      alu_or:    result = op_a | op_b;
      alu_and:   result = op_a & op_b;
      alu_passb: result = op_b;
      default:   result = '0;
    endcase
  end

  assign o_result = result;
  assign o_less   = (i_ctrl.alu_op == alu_sltu) ? less_u : less_s;
  assign o_zero   = (result == '0);
endmodule

//--- design/rv_gpr.sv
// integer register file, x0 reads as zero; two combinational reads, one clocked write
module rv_gpr (
  input  logic          i_clk,
  input  logic          i_reset,
  input  logic          i_wen,
  input  logic [4:0]    i_ra,
  input  logic [4:0]    i_rb,
  input  logic [4:0]    i_waddr,
  input  rv_pkg::xlen_t i_wdata,
  output rv_pkg::xlen_t o_bus_a,
  output rv_pkg::xlen_t o_bus_b
);

  import rv_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && (i_waddr != 5'd0)) begin // x0 never written
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_bus_a = regs[i_ra];
  assign o_bus_b = regs[i_rb];
endmodule

//--- design/rv_idu.sv
// decode unit: turns the fetched word into register indices, immediate and control word
module rv_idu (
  input  rv_pkg::inst_u i_inst,
  output logic [4:0]    o_ra,
  output logic [4:0]    o_rb,
  output logic [4:0]    o_rd,
  output rv_pkg::xlen_t o_imm,
  output rv_pkg::ctrl_t o_ctrl
);

  import rv_pkg::*;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // alt is instruction bit 30; sub exists only in the register form
  function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt,
                                         input logic reg_form);
    alu_op_e op;
    case (funct3)
      3'b000:  op = (alt && reg_form) ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  ctrl_t ctrl;

  assign imm_i = {{52{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
  assign imm_s = {{52{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{51{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{32{i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'h000};
  assign imm_j = {{43{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  always_comb begin
    ctrl  = '0; // unknown opcodes fall through as a no-op
    o_imm = '0;
    case (i_inst.r.opcode)
      op_lui: begin
        ctrl.reg_wr = 1'b1;
        ctrl.b_src  = b_src_imm;
        ctrl.alu_op = alu_passb;
        o_imm       = imm_u;
      end
      op_auipc: begin
        ctrl.reg_wr = 1'b1;
        ctrl.a_src  = a_src_pc;
        ctrl.b_src  = b_src_imm;
        o_imm       = imm_u;
      end
      op_jal, op_jalr: begin
        ctrl.reg_wr = 1'b1;
        ctrl.a_src  = a_src_pc;   // link value pc + 4
        ctrl.b_src  = b_src_four;
        ctrl.branch = (i_inst.r.opcode == op_jal) ? br_jal : br_jalr;
        o_imm       = (i_inst.r.opcode == op_jal) ? imm_j : imm_i;
      end
      op_branch: begin
        ctrl.reg_wr = 1'b0;       // rd field carries offset bits
        ctrl.b_src  = b_src_rs2;
        o_imm       = imm_b;
        case (i_inst.b.funct3)
          3'b000: {ctrl.branch, ctrl.alu_op} = {br_beq, alu_sub};
          3'b001: {ctrl.branch, ctrl.alu_op} = {br_bne, alu_sub};
          3'b100: {ctrl.branch, ctrl.alu_op} = {br_blt, alu_slt};
          3'b101: {ctrl.branch, ctrl.alu_op} = {br_bge, alu_slt};
          3'b110: {ctrl.branch, ctrl.alu_op} = {br_blt, alu_sltu};
          3'b111: {ctrl.branch, ctrl.alu_op} = {br_bge, alu_sltu};
          default: ctrl.branch = br_none;
        endcase
      end
      op_load: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.b_src      = b_src_imm;
        ctrl.mem_to_reg = 1'b1;
        ctrl.mem_op     = mem_op_e'(i_inst.i.funct3);
        o_imm           = imm_i;
      end
      op_store: begin
        ctrl.reg_wr = 1'b0;       // rd field carries offset bits
        ctrl.b_src  = b_src_imm;
        ctrl.mem_wr = 1'b1;
        ctrl.mem_op = mem_op_e'(i_inst.s.funct3);
        o_imm       = imm_s;
      end
      op_imm: begin
        ctrl.reg_wr = 1'b1;
        ctrl.b_src  = b_src_imm;
        ctrl.alu_op = alu_decode(i_inst.i.funct3, i_inst.r.funct7[5], 1'b0);
        o_imm       = imm_i;
      end
      op_reg: begin
        ctrl.reg_wr = 1'b1;
        ctrl.b_src  = b_src_rs2;
        ctrl.alu_op = alu_decode(i_inst.r.funct3, i_inst.r.funct7[5], 1'b1);
      end
      default: ctrl = '0;
    endcase
  end

  assign o_ra   = i_inst.r.rs1;
  assign o_rb   = i_inst.r.rs2;
  assign o_rd   = i_inst.r.rd;
  assign o_ctrl = ctrl;
endmodule

//--- design/rv_ifu.sv
// fetch unit: PC register, next-PC select and the instruction memory loaded from the top port
module rv_ifu #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_run,
  input  rv_pkg::branch_e               i_branch,
  input  logic                          i_less,
  input  logic                          i_zero,
  input  rv_pkg::xlen_t                 i_imm,
  input  rv_pkg::xlen_t                 i_rs1,
  input  logic                          i_imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
  input  logic [31:0]                   i_imem_data,
  output rv_pkg::xlen_t                 o_pc,
  output rv_pkg::inst_u                 o_inst
);

  import rv_pkg::*;

  localparam int AW = $clog2(IMEM_DEPTH);

  logic [31:0] imem [IMEM_DEPTH];
  xlen_t       pc;
  xlen_t       pc_sum;
  xlen_t       next_pc;
  logic        add_imm;  // offset is imm instead of 4
  logic        from_rs1; // base is rs1 instead of pc

  always_comb begin
    add_imm  = 1'b0;
    from_rs1 = 1'b0;
    case (i_branch)
      br_jal:  add_imm = 1'b1;
      br_jalr: begin
        add_imm  = 1'b1;
        from_rs1 = 1'b1;
      end
      br_beq:  add_imm = i_zero;
      br_bne:  add_imm = ~i_zero;
      br_blt:  add_imm = i_less;
      br_bge:  add_imm = ~i_less;
      default: add_imm = 1'b0;
    endcase
  end

  assign pc_sum  = (from_rs1 ? i_rs1 : pc) + (add_imm ? i_imm : 64'd4);
  assign next_pc = {pc_sum[63:1], pc_sum[0] & ~from_rs1};

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc <= '0;
    end else if (i_run) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_data;
    end
  end

  assign o_pc   = pc;
  assign o_inst = imem[pc[AW+1:2]]; // word index
endmodule

//--- design/rv_pkg.sv
// shared types of the RV64I core; imported by every unit and by the top level
package rv_pkg;

  typedef logic [63:0] xlen_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef enum logic [2:0] {
    br_none = 3'b000,  // pc + 4
    br_jal  = 3'b001,  // pc + imm
    br_jalr = 3'b010,  // rs1 + imm, bit 0 cleared
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,  // signedness follows alu_op
    br_bge  = 3'b111
  } branch_e;

  typedef enum logic [3:0] {
    alu_add   = 4'b0000,
    alu_sll   = 4'b0001,
    alu_slt   = 4'b0010,
    alu_passb = 4'b0011,
    alu_xor   = 4'b0100,
    alu_srl   = 4'b0101,
    alu_or    = 4'b0110,
    alu_and   = 4'b0111,
    alu_sub   = 4'b1000,
    alu_sltu  = 4'b1010,
    alu_sra   = 4'b1101
  } alu_op_e;

  // matches the load funct3 encoding
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_d  = 3'b011,
    mem_bu = 3'b100,
    mem_hu = 3'b101,
    mem_wu = 3'b110
  } mem_op_e;

  localparam logic       a_src_rs1  = 1'b0;
  localparam logic       a_src_pc   = 1'b1;
  localparam logic [1:0] b_src_rs2  = 2'd0;
  localparam logic [1:0] b_src_imm  = 2'd1;
  localparam logic [1:0] b_src_four = 2'd2;

  typedef struct packed {
    logic       reg_wr;
    logic       a_src;
    logic [1:0] b_src;
    alu_op_e    alu_op;
    logic       mem_to_reg;
    logic       mem_wr;
    mem_op_e    mem_op;
    branch_e    branch;
  } ctrl_t;

  typedef struct packed {
    logic       en;
    logic [4:0] rd;
    xlen_t      data;
  } wb_t;

endpackage
